// ==== source/barrel_pkg.sv ====
package barrel_pkg;

    // ==============================
    // data widths
    // ==============================
    // register and data word
    typedef logic [31:0] xlen_t;
    // byte address
    typedef logic [31:0] pc_t;
    // raw instruction word
    typedef logic [31:0] instr_t;
    // register index inside one bank
    typedef logic [4:0]  reg_idx_t;

    // ==============================
    // decoded operations
    // ==============================
    typedef enum logic [3:0] {
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_NOP
    } rv_op_t;

    // ==============================
    // encodings
    // ==============================
    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 values of the kept operations
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7, base and alternate (sub)
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // ==============================
    // hart layout
    // ==============================
    // hart h boots at h * stride
    localparam logic [31:0] HART_PC_STRIDE = 32'd4096;
    // issue to writeback distance, so also the minimum hart count
    localparam int PIPE_DEPTH = 4;

endpackage

// ==== source/instr_mem.sv ====
`timescale 1ns/10ps

module instr_mem #(
    parameter int IMEM_DEPTH_LOG2 = 14
) (
    input  logic                       clk,
    input  logic                       w_en,
    input  logic [IMEM_DEPTH_LOG2-1:0] w_addr,
    input  barrel_pkg::instr_t         w_data,
    input  logic [IMEM_DEPTH_LOG2-1:0] r_addr,
    output barrel_pkg::instr_t         r_data
);

    // word array, one instruction per entry
    barrel_pkg::instr_t mem [2**IMEM_DEPTH_LOG2];

    // registered read
    // same-address write in the same cycle returns the old word
    always_ff @(posedge clk) begin
        r_data <= mem[r_addr];
        if (w_en) begin
            mem[w_addr] <= w_data;
        end
    end

endmodule

// ==== source/hart_fetch.sv ====
`timescale 1ns/10ps

module hart_fetch #(
    parameter int NUM_HARTS       = 4,
    parameter int IMEM_DEPTH_LOG2 = 14,
    localparam int HART_W         = $clog2(NUM_HARTS)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic                       pc_upd_en,
    input  logic [HART_W-1:0]          pc_upd_hart,
    input  barrel_pkg::pc_t            pc_upd_target,
    input  logic                       imem_w_en,
    input  logic [IMEM_DEPTH_LOG2-1:0] imem_w_addr,
    input  barrel_pkg::instr_t         imem_w_data,
    output logic                       fetch_valid,
    output logic [HART_W-1:0]          fetch_hart,
    output barrel_pkg::pc_t            fetch_pc,
    output barrel_pkg::instr_t         fetch_instr
);

    logic [HART_W-1:0]          hart_cnt;
    barrel_pkg::pc_t            pc_q [NUM_HARTS];
    logic [IMEM_DEPTH_LOG2-1:0] imem_r_addr;

    // ==============================
    // round-robin scheduler
    // ==============================
    // wraps by itself, hart count is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hart_cnt <= '0;
        end else if (run) begin
            hart_cnt <= hart_cnt + 1'b1;
        end
    end

    // ==============================
    // per-hart program counters
    // ==============================
    // writeback delivers the next pc of every retired instr
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int h = 0; h < NUM_HARTS; h++) begin
                pc_q[h] <= barrel_pkg::HART_PC_STRIDE * h;
            end
        end else if (pc_upd_en) begin
            pc_q[pc_upd_hart] <= pc_upd_target;
        end
    end

    // byte pc to word address
    assign imem_r_addr = pc_q[hart_cnt][IMEM_DEPTH_LOG2+1:2];

    instr_mem #(
        .IMEM_DEPTH_LOG2(IMEM_DEPTH_LOG2)
    ) u_imem (
        .clk   (clk),
        .w_en  (imem_w_en),
        .w_addr(imem_w_addr),
        .w_data(imem_w_data),
        .r_addr(imem_r_addr),
        .r_data(fetch_instr)
    );

    // side info follows the memory read by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= run;
        end
    end

    always_ff @(posedge clk) begin
        fetch_hart <= hart_cnt;
        fetch_pc   <= pc_q[hart_cnt];
    end

endmodule

// ==== source/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder (
    input  barrel_pkg::instr_t   instr,
    output barrel_pkg::rv_op_t   op,
    output barrel_pkg::reg_idx_t rd,
    output barrel_pkg::reg_idx_t rs1,
    output barrel_pkg::reg_idx_t rs2,
    output barrel_pkg::xlen_t    imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // ==============================
    // fixed fields
    // ==============================
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // register fields sit at the same place in every format
    assign rd  = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    // ==============================
    // operation and immediate
    // ==============================
    always_comb begin
        // anything unmatched retires as a no-op
        op  = barrel_pkg::OP_NOP;
        imm = '0;
        case (opcode)
            barrel_pkg::OPC_OP_IMM: begin
                // only addi is kept
                if (funct3 == barrel_pkg::F3_ADD) begin
                    op  = barrel_pkg::OP_ADDI;
                    imm = {{20{instr[31]}}, instr[31:20]};
                end
            end
            barrel_pkg::OPC_OP: begin
                if (funct7 == barrel_pkg::F7_BASE) begin
                    case (funct3)
                        barrel_pkg::F3_ADD: op = barrel_pkg::OP_ADD;
                        barrel_pkg::F3_XOR: op = barrel_pkg::OP_XOR;
                        barrel_pkg::F3_OR:  op = barrel_pkg::OP_OR;
                        barrel_pkg::F3_AND: op = barrel_pkg::OP_AND;
                        default:            op = barrel_pkg::OP_NOP;
                    endcase
                end else if (funct7 == barrel_pkg::F7_ALT && funct3 == barrel_pkg::F3_ADD) begin
                    op = barrel_pkg::OP_SUB;
                end
            end
            barrel_pkg::OPC_LUI: begin
                // upper 20 bits, low part zero
                op  = barrel_pkg::OP_LUI;
                imm = {instr[31:12], 12'b0};
            end
            barrel_pkg::OPC_BRANCH: begin
                if (funct3 == barrel_pkg::F3_BEQ || funct3 == barrel_pkg::F3_BNE) begin
                    op  = (funct3 == barrel_pkg::F3_BEQ) ? barrel_pkg::OP_BEQ
                                                         : barrel_pkg::OP_BNE;
                    // b-type, offset in multiples of two
                    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
                end
            end
            barrel_pkg::OPC_JAL: begin
                op  = barrel_pkg::OP_JAL;
                // j-type, scrambled 20-bit offset
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                op  = barrel_pkg::OP_NOP;
                imm = '0;
            end
        endcase
    end

endmodule

// ==== source/barrel_regfile.sv ====
`timescale 1ns/10ps

module barrel_regfile #(
    parameter int NUM_HARTS = 4,
    localparam int HART_W   = $clog2(NUM_HARTS)
) (
    input  logic                 clk,
    input  logic [HART_W-1:0]    rd_hart,
    input  barrel_pkg::reg_idx_t ra1,
    input  barrel_pkg::reg_idx_t ra2,
    input  logic                 wen,
    input  logic [HART_W-1:0]    w_hart,
    input  barrel_pkg::reg_idx_t wa,
    input  barrel_pkg::xlen_t    wd,
    output barrel_pkg::xlen_t    rd1,
    output barrel_pkg::xlen_t    rd2
);

    // all banks in one array, bank select is the upper index
    barrel_pkg::xlen_t regs [NUM_HARTS*32];

    // ==============================
    // read ports
    // ==============================
    // x0 forced to zero at the output
    always_ff @(posedge clk) begin
        rd1 <= (ra1 == '0) ? '0 : regs[{rd_hart, ra1}];
        rd2 <= (ra2 == '0) ? '0 : regs[{rd_hart, ra2}];
    end

    // ==============================
    // write port
    // ==============================
    // writes to x0 dropped here
    always_ff @(posedge clk) begin
        if (wen && wa != '0) begin
            regs[{w_hart, wa}] <= wd;
        end
    end

endmodule

// ==== source/exec_writeback.sv ====
`timescale 1ns/10ps

module exec_writeback #(
    parameter int NUM_HARTS = 4,
    localparam int HART_W   = $clog2(NUM_HARTS)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic [HART_W-1:0]    in_hart,
    input  barrel_pkg::pc_t      in_pc,
    input  barrel_pkg::rv_op_t   op,
    input  barrel_pkg::reg_idx_t rd,
    input  barrel_pkg::xlen_t    imm,
    input  barrel_pkg::xlen_t    rs1_val,
    input  barrel_pkg::xlen_t    rs2_val,
    output logic                 reg_wen,
    output logic [HART_W-1:0]    reg_hart,
    output barrel_pkg::reg_idx_t reg_wa,
    output barrel_pkg::xlen_t    reg_wd,
    output logic                 pc_upd_en,
    output logic [HART_W-1:0]    pc_upd_hart,
    output barrel_pkg::pc_t      pc_upd_target,
    output logic                 retire_valid,
    output logic [HART_W-1:0]    retire_hart,
    output barrel_pkg::pc_t      retire_pc,
    output logic                 retire_wen,
    output barrel_pkg::reg_idx_t retire_rd,
    output barrel_pkg::xlen_t    retire_data
);

    // stage 1, decoded fields waiting for the regfile read
    logic                 s1_valid;
    logic [HART_W-1:0]    s1_hart;
    barrel_pkg::pc_t      s1_pc;
    barrel_pkg::rv_op_t   s1_op;
    barrel_pkg::reg_idx_t s1_rd;
    barrel_pkg::xlen_t    s1_imm;

    // stage 2 combinational results
    barrel_pkg::xlen_t alu_res;
    barrel_pkg::xlen_t wr_data;
    barrel_pkg::pc_t   pc_plus4;
    barrel_pkg::pc_t   next_pc;
    logic              writes_rd;
    logic              take_branch;

    // stage 2 registers
    logic                 wb_valid;
    logic                 wb_wen;
    logic [HART_W-1:0]    wb_hart;
    barrel_pkg::pc_t      wb_pc;
    barrel_pkg::pc_t      wb_next_pc;
    barrel_pkg::reg_idx_t wb_rd;
    barrel_pkg::xlen_t    wb_data;

    // ==============================
    // stage 1, align with regfile
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_hart <= in_hart;
        s1_pc   <= in_pc;
        s1_op   <= op;
        s1_rd   <= rd;
        s1_imm  <= imm;
    end

    // ==============================
    // stage 2, execute
    // ==============================
    always_comb begin
        alu_res   = rs1_val + s1_imm;
        writes_rd = 1'b1;
        case (s1_op)
            barrel_pkg::OP_ADDI: alu_res = rs1_val + s1_imm;
            barrel_pkg::OP_ADD:  alu_res = rs1_val + rs2_val;
            barrel_pkg::OP_SUB:  alu_res = rs1_val - rs2_val;
            barrel_pkg::OP_AND:  alu_res = rs1_val & rs2_val;
            barrel_pkg::OP_OR:   alu_res = rs1_val | rs2_val;
            barrel_pkg::OP_XOR:  alu_res = rs1_val ^ rs2_val;
            // lui and jal pick their data below
            barrel_pkg::OP_LUI,
            barrel_pkg::OP_JAL:  writes_rd = 1'b1;
            // branches and no-ops leave the regfile alone
            default:             writes_rd = 1'b0;
        endcase
    end

    // branch compare on the raw operands
    assign take_branch = (s1_op == barrel_pkg::OP_BEQ && rs1_val == rs2_val) ||
                         (s1_op == barrel_pkg::OP_BNE && rs1_val != rs2_val);

    assign pc_plus4 = s1_pc + 32'd4;
    assign next_pc  = (take_branch || s1_op == barrel_pkg::OP_JAL) ? s1_pc + s1_imm
                                                                  : pc_plus4;

    // link address for jal, immediate for lui
    assign wr_data = (s1_op == barrel_pkg::OP_JAL) ? pc_plus4 :
                     (s1_op == barrel_pkg::OP_LUI) ? s1_imm   : alu_res;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_wen   <= 1'b0;
        end else begin
            wb_valid <= s1_valid;
            wb_wen   <= s1_valid && writes_rd;
        end
    end

    always_ff @(posedge clk) begin
        wb_hart    <= s1_hart;
        wb_pc      <= s1_pc;
        wb_next_pc <= next_pc;
        wb_rd      <= s1_rd;
        wb_data    <= wr_data;
    end

    // ==============================
    // writeback and retire trace
    // ==============================
    // one register set feeds regfile, pc update and trace
    assign reg_wen       = wb_wen;
    assign reg_hart      = wb_hart;
    assign reg_wa        = wb_rd;
    assign reg_wd        = wb_data;
    assign pc_upd_en     = wb_valid;
    assign pc_upd_hart   = wb_hart;
    assign pc_upd_target = wb_next_pc;
    assign retire_valid  = wb_valid;
    assign retire_hart   = wb_hart;
    assign retire_pc     = wb_pc;
    assign retire_wen    = wb_wen;
    assign retire_rd     = wb_rd;
    assign retire_data   = wb_data;

endmodule

// ==== source/barrel_core.sv ====
`timescale 1ns/10ps

module barrel_core #(
    parameter int NUM_HARTS       = 4,
    parameter int IMEM_DEPTH_LOG2 = 14,
    localparam int HART_W         = $clog2(NUM_HARTS)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic                       imem_w_en,
    input  logic [IMEM_DEPTH_LOG2-1:0] imem_w_addr,
    input  barrel_pkg::instr_t         imem_w_data,
    output logic                       retire_valid,
    output logic [HART_W-1:0]          retire_hart,
    output barrel_pkg::pc_t            retire_pc,
    output logic                       retire_wen,
    output barrel_pkg::reg_idx_t       retire_rd,
    output barrel_pkg::xlen_t          retire_data
);

    // ==============================
    // inter-stage wires
    // ==============================
    logic                 fetch_valid;
    logic [HART_W-1:0]    fetch_hart;
    barrel_pkg::pc_t      fetch_pc;
    barrel_pkg::instr_t   fetch_instr;

    barrel_pkg::rv_op_t   dec_op;
    barrel_pkg::reg_idx_t dec_rd;
    barrel_pkg::reg_idx_t dec_rs1;
    barrel_pkg::reg_idx_t dec_rs2;
    barrel_pkg::xlen_t    dec_imm;

    barrel_pkg::xlen_t    rf_rd1;
    barrel_pkg::xlen_t    rf_rd2;

    logic                 reg_wen;
    logic [HART_W-1:0]    reg_hart;
    barrel_pkg::reg_idx_t reg_wa;
    barrel_pkg::xlen_t    reg_wd;

    logic                 pc_upd_en;
    logic [HART_W-1:0]    pc_upd_hart;
    barrel_pkg::pc_t      pc_upd_target;

    // a hart must retire before its next issue, so no forwarding
    if (NUM_HARTS < barrel_pkg::PIPE_DEPTH || (1 << HART_W) != NUM_HARTS) begin : g_bad_harts
        $error("NUM_HARTS must be a power of two and at least PIPE_DEPTH");
    end

    hart_fetch #(
        .NUM_HARTS      (NUM_HARTS),
        .IMEM_DEPTH_LOG2(IMEM_DEPTH_LOG2)
    ) u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .pc_upd_en    (pc_upd_en),
        .pc_upd_hart  (pc_upd_hart),
        .pc_upd_target(pc_upd_target),
        .imem_w_en    (imem_w_en),
        .imem_w_addr  (imem_w_addr),
        .imem_w_data  (imem_w_data),
        .fetch_valid  (fetch_valid),
        .fetch_hart   (fetch_hart),
        .fetch_pc     (fetch_pc),
        .fetch_instr  (fetch_instr)
    );

    instr_decoder u_dec (
        .instr(fetch_instr),
        .op   (dec_op),
        .rd   (dec_rd),
        .rs1  (dec_rs1),
        .rs2  (dec_rs2),
        .imm  (dec_imm)
    );

    // read side indexed by the fetched hart
    barrel_regfile #(
        .NUM_HARTS(NUM_HARTS)
    ) u_regfile (
        .clk    (clk),
        .rd_hart(fetch_hart),
        .ra1    (dec_rs1),
        .ra2    (dec_rs2),
        .wen    (reg_wen),
        .w_hart (reg_hart),
        .wa     (reg_wa),
        .wd     (reg_wd),
        .rd1    (rf_rd1),
        .rd2    (rf_rd2)
    );

    exec_writeback #(
        .NUM_HARTS(NUM_HARTS)
    ) u_exwb (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (fetch_valid),
        .in_hart      (fetch_hart),
        .in_pc        (fetch_pc),
        .op           (dec_op),
        .rd           (dec_rd),
        .imm          (dec_imm),
        .rs1_val      (rf_rd1),
        .rs2_val      (rf_rd2),
        .reg_wen      (reg_wen),
        .reg_hart     (reg_hart),
        .reg_wa       (reg_wa),
        .reg_wd       (reg_wd),
        .pc_upd_en    (pc_upd_en),
        .pc_upd_hart  (pc_upd_hart),
        .pc_upd_target(pc_upd_target),
        .retire_valid (retire_valid),
        .retire_hart  (retire_hart),
        .retire_pc    (retire_pc),
        .retire_wen   (retire_wen),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

// ==== tb/core_tests.svh ====
`ifndef CORE_TESTS_SVH
`define CORE_TESTS_SVH

// ==============================
// directed tests
// ==============================

// no retire during reset or while run stays low
task automatic test_idle();
    apply_reset();
    repeat (16) begin
        @(posedge clk);
        check_flag("retire_valid", 1'b0, retire_valid);
    end
endtask

// alu chain with random immediates, ends in a self loop
task automatic queue_alu_chain();
    put(enc_addi(5'd1, 5'd0, 12'($random(seed))));
    put(enc_addi(5'd2, 5'd0, 12'($random(seed))));
    put(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    put(enc_r(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));
    put(enc_r(7'h00, 5'd2, 5'd3, 3'd7, 5'd5));
    put(enc_r(7'h00, 5'd1, 5'd4, 3'd6, 5'd6));
    put(enc_r(7'h00, 5'd5, 5'd6, 3'd4, 5'd7));
    put(enc_lui(5'd8, 20'($random(seed))));
    put(enc_addi(5'd9, 5'd8, 12'($random(seed))));
    put(enc_j(5'd0, 21'd0));
endtask

task automatic test_alu_chain();
    apply_reset();
    queue_alu_chain();
    load_hart(0);
    for (int h = 1; h < NUM_HARTS; h++) begin
        park_hart(h);
    end
    run_program(12 * NUM_HARTS);
endtask

// same code on every hart, separate immediates per bank
task automatic test_all_harts();
    apply_reset();
    for (int h = 0; h < NUM_HARTS; h++) begin
        queue_alu_chain();
        load_hart(h);
    end
    run_program(12 * NUM_HARTS);
endtask

task automatic test_branches();
    apply_reset();
    put(enc_addi(5'd1, 5'd0, 12'd5));
    put(enc_addi(5'd2, 5'd0, 12'd5));
    // beq taken, skips one
    put(enc_b(3'd0, 5'd1, 5'd2, 13'd8));
    put(enc_addi(5'd3, 5'd0, 12'd1));
    // bne not taken, then bne taken
    put(enc_b(3'd1, 5'd1, 5'd2, 13'd8));
    put(enc_b(3'd1, 5'd1, 5'd0, 13'd8));
    put(enc_addi(5'd3, 5'd0, 12'd2));
    // beq not taken
    put(enc_b(3'd0, 5'd1, 5'd0, 13'd8));
    // jal links pc+4 into x5
    put(enc_j(5'd5, 21'd8));
    put(enc_addi(5'd3, 5'd0, 12'd3));
    put(enc_j(5'd0, 21'd0));
    load_hart(0);
    for (int h = 1; h < NUM_HARTS; h++) begin
        park_hart(h);
    end
    run_program(10 * NUM_HARTS);
endtask

// x0 write shows on the trace but reads stay zero
task automatic test_x0();
    apply_reset();
    put(enc_addi(5'd6, 5'd0, 12'($random(seed))));
    put(enc_addi(5'd0, 5'd0, 12'($random(seed))));
    put(enc_r(7'h00, 5'd6, 5'd0, 3'd0, 5'd4));
    put(enc_r(7'h00, 5'd0, 5'd6, 3'd0, 5'd7));
    put(enc_j(5'd0, 21'd0));
    load_hart(0);
    for (int h = 1; h < NUM_HARTS; h++) begin
        park_hart(h);
    end
    run_program(6 * NUM_HARTS);
endtask

// ecall and an all-ones word both retire as no-ops
task automatic test_unsupported();
    apply_reset();
    put(32'h0000_0073);
    put(enc_addi(5'd1, 5'd0, 12'd7));
    put(32'hffff_ffff);
    put(enc_addi(5'd2, 5'd1, 12'd1));
    put(enc_j(5'd0, 21'd0));
    load_hart(0);
    for (int h = 1; h < NUM_HARTS; h++) begin
        park_hart(h);
    end
    run_program(6 * NUM_HARTS);
endtask

`endif

// ==== tb/tb_barrel_core.sv ====
`timescale 1ns/10ps

module tb_barrel_core;

    localparam int NUM_HARTS = 4;
    localparam int IMEM_AW   = 14;
    // six tests, each reset + load + run + drain well under 300 cycles
    localparam int TEST_CYCLES = 6 * 300;
    localparam int LIMIT_NS    = (TEST_CYCLES + 500) * 8;

    logic                       clk;
    logic                       rst_n;
    logic                       run;
    logic                       imem_w_en;
    logic [IMEM_AW-1:0]         imem_w_addr;
    barrel_pkg::instr_t         imem_w_data;
    logic                       retire_valid;
    logic [1:0]                 retire_hart;
    barrel_pkg::pc_t            retire_pc;
    logic                       retire_wen;
    barrel_pkg::reg_idx_t       retire_rd;
    barrel_pkg::xlen_t          retire_data;

    // ==============================
    // reference model state
    // ==============================
    barrel_pkg::xlen_t  model_regs [NUM_HARTS][32];
    barrel_pkg::pc_t    model_pc [NUM_HARTS];
    barrel_pkg::instr_t mem_img [int];
    barrel_pkg::instr_t prog [$];
    int                 exp_hart;
    int                 retire_cnt;
    bit                 expect_retire;
    int                 err_cnt;
    int                 check_cnt;
    int                 seed;

    barrel_core #(
        .NUM_HARTS      (NUM_HARTS),
        .IMEM_DEPTH_LOG2(IMEM_AW)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .imem_w_en   (imem_w_en),
        .imem_w_addr (imem_w_addr),
        .imem_w_data (imem_w_data),
        .retire_valid(retire_valid),
        .retire_hart (retire_hart),
        .retire_pc   (retire_pc),
        .retire_wen  (retire_wen),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

    always #4 clk = ~clk;

    // ==============================
    // compare tasks
    // ==============================
    task automatic check_data(string name, barrel_pkg::xlen_t exp, barrel_pkg::xlen_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_pc(string name, barrel_pkg::pc_t exp, barrel_pkg::pc_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // register indices and hart numbers
    task automatic check_idx(string name, barrel_pkg::reg_idx_t exp, barrel_pkg::reg_idx_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // ==============================
    // instruction encoders
    // ==============================
    function automatic barrel_pkg::instr_t enc_r(logic [6:0] f7, logic [4:0] rs2,
                                                  logic [4:0] rs1, logic [2:0] f3,
                                                  logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, barrel_pkg::OPC_OP};
    endfunction

    function automatic barrel_pkg::instr_t enc_addi(logic [4:0] rd, logic [4:0] rs1,
                                                     logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, barrel_pkg::OPC_OP_IMM};
    endfunction

    function automatic barrel_pkg::instr_t enc_lui(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, barrel_pkg::OPC_LUI};
    endfunction

    function automatic barrel_pkg::instr_t enc_b(logic [2:0] f3, logic [4:0] rs1,
                                                  logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], barrel_pkg::OPC_BRANCH};
    endfunction

    function automatic barrel_pkg::instr_t enc_j(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, barrel_pkg::OPC_JAL};
    endfunction

    // ==============================
    // program loading
    // ==============================
    task automatic put(barrel_pkg::instr_t instr);
        prog.push_back(instr);
    endtask

    // writes the queued program at the hart's boot address
    task automatic load_hart(int h);
        int base;
        base = h * (barrel_pkg::HART_PC_STRIDE / 4);
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            imem_w_en   <= 1'b1;
            imem_w_addr <= IMEM_AW'(base + i);
            imem_w_data <= prog[i];
            mem_img[base + i] = prog[i];
        end
        @(posedge clk);
        imem_w_en <= 1'b0;
        prog.delete();
    endtask

    // self loop, jal x0 with zero offset
    task automatic park_hart(int h);
        put(enc_j(5'd0, 21'd0));
        load_hart(h);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        run   <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int h = 0; h < NUM_HARTS; h++) begin
            model_pc[h] = barrel_pkg::HART_PC_STRIDE * h;
        end
        exp_hart = 0;
    endtask

    // ==============================
    // model step for one retire
    // ==============================
    task automatic model_step(int h, output logic wen, output barrel_pkg::reg_idx_t rd,
                              output barrel_pkg::xlen_t data);
        barrel_pkg::instr_t i;
        barrel_pkg::xlen_t  a;
        barrel_pkg::xlen_t  b;
        barrel_pkg::pc_t    pc;
        barrel_pkg::pc_t    nxt;
        pc   = model_pc[h];
        i    = mem_img.exists(int'(pc[15:2])) ? mem_img[int'(pc[15:2])] : '0;
        a    = (i[19:15] == 0) ? '0 : model_regs[h][i[19:15]];
        b    = (i[24:20] == 0) ? '0 : model_regs[h][i[24:20]];
        rd   = i[11:7];
        wen  = 1'b0;
        data = '0;
        nxt  = pc + 4;
        case (i[6:0])
            barrel_pkg::OPC_OP_IMM: if (i[14:12] == 3'b000) begin
                wen  = 1'b1;
                data = a + {{20{i[31]}}, i[31:20]};
            end
            barrel_pkg::OPC_OP: begin
                wen = 1'b1;
                if (i[31:25] == 7'h00 && i[14:12] == 3'd0) data = a + b;
                else if (i[31:25] == 7'h20 && i[14:12] == 3'd0) data = a - b;
                else if (i[31:25] == 7'h00 && i[14:12] == 3'd4) data = a ^ b;
                else if (i[31:25] == 7'h00 && i[14:12] == 3'd6) data = a | b;
                else if (i[31:25] == 7'h00 && i[14:12] == 3'd7) data = a & b;
                else wen = 1'b0;
            end
            barrel_pkg::OPC_LUI: begin
                wen  = 1'b1;
                data = {i[31:12], 12'b0};
            end
            barrel_pkg::OPC_BRANCH: begin
                if ((i[14:12] == 3'd0 && a == b) || (i[14:12] == 3'd1 && a != b)) begin
                    nxt = pc + {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
                end
            end
            barrel_pkg::OPC_JAL: begin
                wen  = 1'b1;
                data = pc + 4;
                nxt  = pc + {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            end
            default: wen = 1'b0;
        endcase
        if (wen && rd != 0) begin
            model_regs[h][rd] = data;
        end
        model_pc[h] = nxt;
    endtask

    // ==============================
    // retire monitor
    // ==============================
    always @(posedge clk) begin : retire_monitor
        logic                 wen;
        barrel_pkg::reg_idx_t rd;
        barrel_pkg::xlen_t    data;
        barrel_pkg::pc_t      pc;
        if (retire_valid === 1'b1) begin
            if (!expect_retire) begin
                err_cnt++;
                $display("error at %0t: a retire appeared while the core was idle", $time);
            end else begin
                pc = model_pc[exp_hart];
                model_step(exp_hart, wen, rd, data);
                check_idx("retire_hart", 5'(exp_hart), 5'(retire_hart));
                check_pc("retire_pc", pc, retire_pc);
                check_flag("retire_wen", wen, retire_wen);
                if (wen) begin
                    check_idx("retire_rd", rd, retire_rd);
                    check_data("retire_data", data, retire_data);
                end
                exp_hart   = (exp_hart + 1) % NUM_HARTS;
                retire_cnt = retire_cnt + 1;
            end
        end
    end

    // runs until the given number of retires, then drains the pipe
    task automatic run_program(int n_retires);
        int waited;
        retire_cnt    = 0;
        expect_retire = 1'b1;
        @(posedge clk);
        run    <= 1'b1;
        waited = 0;
        while (retire_cnt < n_retires && waited < n_retires + 20) begin
            @(posedge clk);
            waited++;
        end
        if (retire_cnt < n_retires) begin
            err_cnt++;
            $display("error at %0t: missing retire, got %0d of %0d", $time,
                     retire_cnt, n_retires);
        end
        run <= 1'b0;
        repeat (6) @(posedge clk);
        expect_retire = 1'b0;
    endtask

    `include "core_tests.svh"

    // ==============================
    // watchdog
    // ==============================
    initial begin
        #(LIMIT_NS);
        $display("timeout: the tests did not finish in %0d ns", LIMIT_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        run           = 1'b0;
        imem_w_en     = 1'b0;
        imem_w_addr   = '0;
        imem_w_data   = '0;
        expect_retire = 1'b0;
        err_cnt       = 0;
        check_cnt     = 0;
        retire_cnt    = 0;
        exp_hart      = 0;
        seed          = 32'hfaf0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            for (int r = 0; r < 32; r++) begin
                model_regs[h][r] = '0;
            end
        end
        test_idle();
        test_alu_chain();
        test_all_harts();
        test_branches();
        test_x0();
        test_unsupported();
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+tb
source/barrel_pkg.sv
source/instr_mem.sv
source/hart_fetch.sv
source/instr_decoder.sv
source/barrel_regfile.sv
source/exec_writeback.sv
source/barrel_core.sv
tb/tb_barrel_core.sv

// ==== Makefile ====
TOP := tb_barrel_core
BIN := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
